/* erx_pkg.sv */
package erx_pkg;

  // Packet width of the mesh link
  localparam int PW = 104;

  // Field positions inside a packet
  localparam int WRITE_BIT   = 0;
  localparam int DSTADDR_LSB = 8;
  localparam int DATA_LSB    = 40;
  localparam int SRCADDR_LSB = 72;

  // Address group marking a read response, dstaddr[19:16]
  localparam logic [3:0] EGROUP_READTAG = 4'h8;

  // Data word carried by a synthetic timeout response
  localparam logic [31:0] TIMEOUT_DATA = 32'hDEADBEEF;

  // Raw packet as seen on every port
  typedef logic [PW-1:0] packet_t;

  //##########################################################################
  // Field extraction
  //##########################################################################

  // Write flag, low for a read
  function automatic logic pkt_write(input packet_t pkt);
    return pkt[WRITE_BIT];
  endfunction

  // Destination address
  function automatic logic [31:0] pkt_dstaddr(input packet_t pkt);
    return pkt[DSTADDR_LSB +: 32];
  endfunction

  // Data word
  function automatic logic [31:0] pkt_data(input packet_t pkt);
    return pkt[DATA_LSB +: 32];
  endfunction

  // Source address, return address of a read
  function automatic logic [31:0] pkt_srcaddr(input packet_t pkt);
    return pkt[SRCADDR_LSB +: 32];
  endfunction

endpackage

/* erx_remap.sv */
module erx_remap #(
  parameter logic [11:0] REMAP_SEL = 12'h3f0,
  parameter logic [11:0] REMAP_PAT = 12'h820
) (
  input  logic             clk,
  input  logic             rst,
  // Link side
  input  logic             erx_access,
  input  erx_pkg::packet_t erx_packet,
  input  logic             erx_wait,
  // Toward the distributor
  output logic             emmu_access,
  output erx_pkg::packet_t emmu_packet
);

  import erx_pkg::*;

  logic [31:0] in_dstaddr;
  logic        window_hit;
  logic [31:0] new_dstaddr;
  packet_t     remap_packet;

  //##########################################################################
  // Address rewrite
  //##########################################################################

  assign in_dstaddr = pkt_dstaddr(erx_packet);

  // Upper 12 bits select the window
  assign window_hit = (in_dstaddr[31:20] == REMAP_SEL);

  // Replace only the window bits, keep the offset
  assign new_dstaddr = window_hit ? {REMAP_PAT, in_dstaddr[19:0]} : in_dstaddr;

  always_comb begin
    remap_packet = erx_packet;
    remap_packet[DSTADDR_LSB +: 32] = new_dstaddr;
  end

  //##########################################################################
  // One-entry register stage
  //##########################################################################

  // Valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      emmu_access <= 1'b0;
    end else if (!erx_wait) begin
      emmu_access <= erx_access;
    end
  end

  // Payload, only loaded with a real packet
  always_ff @(posedge clk) begin
    if (!erx_wait && erx_access) begin
      emmu_packet <= remap_packet;
    end
  end

  // Held entry stays put while the queues push back
  hold_while_wait: assert property (
    @(posedge clk) disable iff (rst)
    (emmu_access && erx_wait) |=> (emmu_access && $stable(emmu_packet))
  ) else $error("remap entry changed while erx_wait was high");

endmodule

/* erx_read_timer.sv */
module erx_read_timer #(
  parameter int TIMEOUT_CYCLES = 40
) (
  input  logic clk,
  input  logic rst,
  // Read sent into the read queue
  input  logic rd_issue,
  // Any read response from the link
  input  logic rr_seen,
  output logic erx_timeout
);

  localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

  typedef enum logic {
    IDLE,
    COUNT
  } state_t;

  state_t        state;
  logic [CW-1:0] cnt;

  //##########################################################################
  // Idle/count FSM
  //##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      cnt         <= '0;
      erx_timeout <= 1'b0;
    end else begin
      // Pulse lasts one cycle by default
      erx_timeout <= 1'b0;
      case (state)
        IDLE: begin
          // Only one read is tracked at a time
          if (rd_issue && !rr_seen) begin
            state <= COUNT;
            cnt   <= CW'(TIMEOUT_CYCLES - 1);
          end
        end
        COUNT: begin
          if (rr_seen) begin
            state <= IDLE;
          end else if (cnt == '0) begin
            // Expired, flag and go idle
            state       <= IDLE;
            erx_timeout <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Distributor relies on a single-cycle pulse
  single_pulse: assert property (
    @(posedge clk) disable iff (rst)
    erx_timeout |=> !erx_timeout
  ) else $error("erx_timeout held for more than one cycle");

endmodule

/* erx_disty.sv */
module erx_disty #(
  parameter logic [11:0] ID = 12'h800
) (
  // From the link
  input  logic             erx_access,
  input  erx_pkg::packet_t erx_packet,
  // From the remap stage
  input  logic             emmu_access,
  input  erx_pkg::packet_t emmu_packet,
  // From the DMA port
  input  logic             edma_access,
  input  erx_pkg::packet_t edma_packet,
  // Read timer
  input  logic             erx_timeout,
  output logic             rd_issue,
  output logic             rr_seen,
  // Queue waits
  input  logic             wr_fifo_wait,
  input  logic             rd_fifo_wait,
  input  logic             rr_fifo_wait,
  // Waits toward the sources
  output logic             erx_wait,
  output logic             rx_rd_wait,
  output logic             rx_wr_wait,
  output logic             edma_wait,
  // Queue writes
  output logic             wr_fifo_access,
  output erx_pkg::packet_t wr_fifo_packet,
  output logic             rd_fifo_access,
  output erx_pkg::packet_t rd_fifo_packet,
  output logic             rr_fifo_access,
  output erx_pkg::packet_t rr_fifo_packet
);

  import erx_pkg::*;

  logic [31:0] erx_dstaddr;
  logic [31:0] emmu_dstaddr;
  logic        emmu_read;
  logic        emmu_rd_go;
  logic        edma_go;
  logic        link_rr;
  packet_t     timeout_packet;

  assign erx_dstaddr  = pkt_dstaddr(erx_packet);
  assign emmu_dstaddr = pkt_dstaddr(emmu_packet);

  //##########################################################################
  // Read response path, straight from the link
  //##########################################################################

  // Write to this link's read-tag group, accepted this edge
  assign link_rr = erx_access & ~erx_wait & pkt_write(erx_packet) &
                   (erx_dstaddr[31:20] == ID) &
                   (erx_dstaddr[19:16] == EGROUP_READTAG);

  // Synthetic error response
  assign timeout_packet = {32'h0, TIMEOUT_DATA, ID, EGROUP_READTAG, 16'h0000, 8'h03};

  // Timeout wins over a link response
  assign rr_fifo_access = erx_timeout | link_rr;
  assign rr_fifo_packet = erx_timeout ? timeout_packet : erx_packet;
  assign rr_seen        = link_rr;

  //##########################################################################
  // Write path, remapped packets
  //##########################################################################

  // Writes aimed at this link itself are dropped
  assign wr_fifo_access = emmu_access & ~erx_wait & pkt_write(emmu_packet) &
                          (emmu_dstaddr[31:20] != ID);
  assign wr_fifo_packet = emmu_packet;

  //##########################################################################
  // Read path, remapped reads merged with DMA
  //##########################################################################

  // Pending remapped read blocks the DMA port
  assign emmu_read  = emmu_access & ~pkt_write(emmu_packet);
  assign emmu_rd_go = emmu_read & ~erx_wait;
  assign edma_go    = edma_access & ~edma_wait;

  assign rd_fifo_access = emmu_rd_go | edma_go;
  assign rd_fifo_packet = emmu_read ? emmu_packet : edma_packet;

  // Timer watches link reads only
  assign rd_issue = emmu_rd_go;

  //##########################################################################
  // Wait signals
  //##########################################################################

  assign rx_rd_wait = rd_fifo_wait;
  assign rx_wr_wait = wr_fifo_wait | rr_fifo_wait;
  assign edma_wait  = rd_fifo_wait | emmu_read;
  assign erx_wait   = rx_rd_wait | rx_wr_wait;

endmodule

/* erx_fifo.sv */
module erx_fifo #(
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  // Write side
  input  logic             in_access,
  input  erx_pkg::packet_t in_packet,
  output logic             in_wait,
  // Read side, registered head
  output logic             out_access,
  output erx_pkg::packet_t out_packet,
  input  logic             out_wait
);

  import erx_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 1;

  packet_t       mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          push;
  logic          pop_head;
  logic          load_head;

  //##########################################################################
  // Control
  //##########################################################################

  // Writes past full would be lost, wait goes up early
  assign push      = in_access & (cnt != CW'(DEPTH));
  assign pop_head  = out_access & ~out_wait;
  assign load_head = (cnt != '0) & (~out_access | pop_head);

  // Two free slots left for packets already in flight
  assign in_wait = (cnt >= CW'(DEPTH - 2));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load_head) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      cnt <= cnt + CW'(push) - CW'(load_head);
    end
  end

  // Head valid
  always_ff @(posedge clk) begin
    if (rst) begin
      out_access <= 1'b0;
    end else if (load_head) begin
      out_access <= 1'b1;
    end else if (pop_head) begin
      out_access <= 1'b0;
    end
  end

  //##########################################################################
  // Storage
  //##########################################################################

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Head payload
  always_ff @(posedge clk) begin
    if (load_head) begin
      out_packet <= mem[rd_ptr];
    end
  end

  // Upstream must respect wait before the buffer runs out
  no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    in_access |-> (cnt != CW'(DEPTH))
  ) else $error("write into a full FIFO");

  // Head only empties through a real pop
  no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    $fell(out_access) |-> $past(out_access && !out_wait)
  ) else $error("FIFO head lost without a pop");

endmodule

/* erx_top.sv */
module erx_top #(
  parameter logic [11:0] ID             = 12'h800,
  parameter logic [11:0] REMAP_SEL      = 12'h3f0,
  parameter logic [11:0] REMAP_PAT      = 12'h820,
  parameter int          TIMEOUT_CYCLES = 40,
  parameter int          DEPTH          = 8
) (
  input  logic             clk,
  input  logic             rst,
  // Link input
  input  logic             erx_access,
  input  erx_pkg::packet_t erx_packet,
  // DMA input
  input  logic             edma_access,
  input  erx_pkg::packet_t edma_packet,
  output logic             edma_wait,
  // Waits toward the I/O side
  output logic             erx_wait,
  output logic             rx_rd_wait,
  output logic             rx_wr_wait,
  // Write queue
  output logic             rxwr_access,
  output erx_pkg::packet_t rxwr_packet,
  input  logic             rxwr_wait,
  // Read queue
  output logic             rxrd_access,
  output erx_pkg::packet_t rxrd_packet,
  input  logic             rxrd_wait,
  // Read-response queue
  output logic             rxrr_access,
  output erx_pkg::packet_t rxrr_packet,
  input  logic             rxrr_wait
);

  import erx_pkg::*;

  // Remap to distributor
  logic    emmu_access;
  packet_t emmu_packet;

  // Timer handshake
  logic    erx_timeout;
  logic    rd_issue;
  logic    rr_seen;

  // Distributor to queues
  logic    wr_fifo_access;
  packet_t wr_fifo_packet;
  logic    wr_fifo_wait;
  logic    rd_fifo_access;
  packet_t rd_fifo_packet;
  logic    rd_fifo_wait;
  logic    rr_fifo_access;
  packet_t rr_fifo_packet;
  logic    rr_fifo_wait;

  //##########################################################################
  // Front end
  //##########################################################################

  erx_remap #(.REMAP_SEL(REMAP_SEL), .REMAP_PAT(REMAP_PAT)) remap (
    .clk(clk), .rst(rst),
    .erx_access(erx_access), .erx_packet(erx_packet), .erx_wait(erx_wait),
    .emmu_access(emmu_access), .emmu_packet(emmu_packet)
  );

  erx_read_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) read_timer (
    .clk(clk), .rst(rst),
    .rd_issue(rd_issue), .rr_seen(rr_seen), .erx_timeout(erx_timeout)
  );

  erx_disty #(.ID(ID)) disty (
    .erx_access(erx_access), .erx_packet(erx_packet),
    .emmu_access(emmu_access), .emmu_packet(emmu_packet),
    .edma_access(edma_access), .edma_packet(edma_packet),
    .erx_timeout(erx_timeout), .rd_issue(rd_issue), .rr_seen(rr_seen),
    .wr_fifo_wait(wr_fifo_wait), .rd_fifo_wait(rd_fifo_wait),
    .rr_fifo_wait(rr_fifo_wait),
    .erx_wait(erx_wait), .rx_rd_wait(rx_rd_wait), .rx_wr_wait(rx_wr_wait),
    .edma_wait(edma_wait),
    .wr_fifo_access(wr_fifo_access), .wr_fifo_packet(wr_fifo_packet),
    .rd_fifo_access(rd_fifo_access), .rd_fifo_packet(rd_fifo_packet),
    .rr_fifo_access(rr_fifo_access), .rr_fifo_packet(rr_fifo_packet)
  );

  //##########################################################################
  // Output queues
  //##########################################################################

  erx_fifo #(.DEPTH(DEPTH)) wr_fifo (
    .clk(clk), .rst(rst),
    .in_access(wr_fifo_access), .in_packet(wr_fifo_packet), .in_wait(wr_fifo_wait),
    .out_access(rxwr_access), .out_packet(rxwr_packet), .out_wait(rxwr_wait)
  );

  erx_fifo #(.DEPTH(DEPTH)) rd_fifo (
    .clk(clk), .rst(rst),
    .in_access(rd_fifo_access), .in_packet(rd_fifo_packet), .in_wait(rd_fifo_wait),
    .out_access(rxrd_access), .out_packet(rxrd_packet), .out_wait(rxrd_wait)
  );

  erx_fifo #(.DEPTH(DEPTH)) rr_fifo (
    .clk(clk), .rst(rst),
    .in_access(rr_fifo_access), .in_packet(rr_fifo_packet), .in_wait(rr_fifo_wait),
    .out_access(rxrr_access), .out_packet(rxrr_packet), .out_wait(rxrr_wait)
  );

endmodule

/* tb_erx.sv */
module tb_erx;

  timeunit 1ns;
  timeprecision 1ps;

  import erx_pkg::*;

  // DUT configuration
  localparam logic [11:0] LINK_ID     = 12'h800;
  localparam logic [11:0] WIN_SEL     = 12'h3f0;
  localparam logic [11:0] WIN_PAT     = 12'h820;
  localparam logic [3:0]  RR_GROUP    = 4'h8;
  localparam int          TMO_CYCLES  = 40;
  localparam int          DEPTH       = 8;
  localparam int          STIM_CYCLES = 800;
  localparam int          MAX_CYCLES  = 4 * STIM_CYCLES + 500;

  // Synthetic response: srcaddr 0, data DEADBEEF, read-tag address, low byte 03
  localparam packet_t TMO_PACKET = {32'h0, 32'hDEADBEEF, LINK_ID, RR_GROUP, 16'h0000, 8'h03};

  logic    clk = 1'b0;
  logic    rst;
  logic    erx_access;
  packet_t erx_packet;
  logic    edma_access;
  packet_t edma_packet;
  logic    edma_wait;
  logic    erx_wait;
  logic    rx_rd_wait;
  logic    rx_wr_wait;
  logic    rxwr_access;
  packet_t rxwr_packet;
  logic    rxwr_wait;
  logic    rxrd_access;
  packet_t rxrd_packet;
  logic    rxrd_wait;
  logic    rxrr_access;
  packet_t rxrr_packet;
  logic    rxrr_wait;

  integer  seed    = 32'hca332dbe;
  int      errors  = 0;
  int      checked = 0;
  int      cycles  = 0;

  // Expected contents of the three queues, oldest first
  packet_t exp_wr[$];
  packet_t exp_rd[$];
  packet_t exp_rr[$];

  // Model of the remap register and the read timer
  logic    pend_valid = 1'b0;
  packet_t pend_pkt   = '0;
  logic    m_busy     = 1'b0;
  int      m_cnt      = 0;
  logic    m_tmo      = 1'b0;

  // Sender state, a packet is held until accepted
  logic    link_busy = 1'b0;
  logic    link_acc  = 1'b0;
  packet_t link_pkt  = '0;
  logic    dma_busy  = 1'b0;
  logic    dma_acc   = 1'b0;
  packet_t dma_pkt   = '0;
  int      wr_run    = 0;
  int      rd_run    = 0;
  logic    tmo_phase = 1'b0;
  int      tmo_seen  = 0;

  always #5 clk = ~clk;

  erx_top #(
    .ID(LINK_ID), .REMAP_SEL(WIN_SEL), .REMAP_PAT(WIN_PAT),
    .TIMEOUT_CYCLES(TMO_CYCLES), .DEPTH(DEPTH)
  ) erx_top_inst (
    .clk(clk), .rst(rst),
    .erx_access(erx_access), .erx_packet(erx_packet),
    .edma_access(edma_access), .edma_packet(edma_packet), .edma_wait(edma_wait),
    .erx_wait(erx_wait), .rx_rd_wait(rx_rd_wait), .rx_wr_wait(rx_wr_wait),
    .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet), .rxwr_wait(rxwr_wait),
    .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet), .rxrd_wait(rxrd_wait),
    .rxrr_access(rxrr_access), .rxrr_packet(rxrr_packet), .rxrr_wait(rxrr_wait)
  );

  //##########################################################################
  // Helpers
  //##########################################################################

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Window rewrite of dstaddr[31:20], packet bits 39:28
  function automatic packet_t apply_window(input packet_t p);
    packet_t q;
    q = p;
    if (p[39:28] == WIN_SEL) begin
      q[39:28] = WIN_PAT;
    end
    return q;
  endfunction

  // Write to this link's read-tag group
  function automatic logic is_response(input packet_t p);
    return p[0] && (p[39:28] == LINK_ID) && (p[27:24] == RR_GROUP);
  endfunction

  function automatic packet_t make_link_packet();
    packet_t    p;
    logic [2:0] kind;
    kind = 3'(rand32());
    p    = {rand32(), rand32(), rand32(), 8'(rand32())};
    case (kind)
      3'd0, 3'd1: p[0] = 1'b1;
      3'd2: begin
        p[0]     = 1'b1;
        p[39:28] = WIN_SEL;
      end
      3'd3: begin
        // Write to this link outside the read-tag group, dropped
        p[0]     = 1'b1;
        p[39:28] = LINK_ID;
        p[27]    = 1'b0;
      end
      3'd4, 3'd5: p[0] = 1'b0;
      3'd6: begin
        p[0]     = 1'b1;
        p[39:28] = LINK_ID;
        p[27:24] = RR_GROUP;
      end
      default: begin
        p[0]     = 1'b0;
        p[39:28] = WIN_SEL;
      end
    endcase
    return p;
  endfunction

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_packet(input string name, input packet_t exp_p, input packet_t act_p);
    checked++;
    if (act_p !== exp_p) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp_p, act_p);
    end
  endtask

  // Pop the matching queue and compare, 0 write, 1 read, 2 response
  task automatic take_output(input int q, input string name, input packet_t act);
    int      n;
    packet_t exp_p;
    n = (q == 0) ? exp_wr.size() : (q == 1) ? exp_rd.size() : exp_rr.size();
    if (n == 0) begin
      errors++;
      $display("Packet %h left on %s while nothing was expected there", act, name);
    end else begin
      if (q == 0) begin
        exp_p = exp_wr.pop_front();
      end else if (q == 1) begin
        exp_p = exp_rd.pop_front();
      end else begin
        exp_p = exp_rr.pop_front();
      end
      compare_packet(name, exp_p, act);
    end
  endtask

  task automatic check_reset_state();
    check_bit("rxwr_access", 1'b0, rxwr_access);
    check_bit("rxrd_access", 1'b0, rxrd_access);
    check_bit("rxrr_access", 1'b0, rxrr_access);
    check_bit("erx_wait", 1'b0, erx_wait);
    check_bit("rx_rd_wait", 1'b0, rx_rd_wait);
    check_bit("rx_wr_wait", 1'b0, rx_wr_wait);
    check_bit("erx_timeout", 1'b0, erx_top_inst.erx_timeout);
  endtask

  // Falling-edge driver, new packets only once the held one is taken
  task automatic drive_inputs(input logic new_items, input logic pressure);
    if (link_acc) begin
      link_busy = 1'b0;
    end
    if (dma_acc) begin
      dma_busy = 1'b0;
    end
    if (new_items && !link_busy && (rand32() & 32'd3) != 0) begin
      link_pkt  = make_link_packet();
      link_busy = 1'b1;
    end
    if (new_items && !dma_busy && (rand32() % 3) == 0) begin
      dma_pkt    = {rand32(), rand32(), rand32(), 8'(rand32())};
      dma_pkt[0] = 1'b0;
      dma_busy   = 1'b1;
    end
    erx_access  = link_busy;
    erx_packet  = link_pkt;
    edma_access = dma_busy;
    edma_packet = dma_pkt;
    if (pressure) begin
      // Runs of back-pressure, high ones up to 32 cycles
      if (wr_run == 0) begin
        rxwr_wait = ((rand32() & 32'd3) == 0);
        wr_run    = rxwr_wait ? 1 + int'(rand32() & 32'd31) : 1 + int'(rand32() & 32'd7);
      end
      if (rd_run == 0) begin
        rxrd_wait = ((rand32() & 32'd3) == 0);
        rd_run    = rxrd_wait ? 1 + int'(rand32() & 32'd31) : 1 + int'(rand32() & 32'd7);
      end
      wr_run--;
      rd_run--;
      rxrr_wait = ((rand32() & 32'd7) == 0);
    end else begin
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      wr_run    = 0;
      rd_run    = 0;
    end
  endtask

  //##########################################################################
  // Monitor and reference model, values seen just before each rising edge
  //##########################################################################

  always @(posedge clk) begin : monitor
    logic link_go;
    logic dma_go;
    logic rr_hit;
    logic issue;
    logic tmo_next;
    if (!rst) begin
      // Full queues must push back
      if (exp_wr.size() >= DEPTH - 1 || exp_rr.size() >= DEPTH - 1) begin
        check_bit("rx_wr_wait", 1'b1, rx_wr_wait);
        check_bit("erx_wait", 1'b1, erx_wait);
      end
      if (exp_rd.size() >= DEPTH - 1) begin
        check_bit("rx_rd_wait", 1'b1, rx_rd_wait);
        check_bit("erx_wait", 1'b1, erx_wait);
        check_bit("edma_wait", 1'b1, edma_wait);
      end
      // Remapped read in the register blocks the DMA port
      if (pend_valid && !pend_pkt[0]) begin
        check_bit("edma_wait", 1'b1, edma_wait);
      end

      if (rxwr_access && !rxwr_wait) begin
        take_output(0, "rxwr_packet", rxwr_packet);
      end
      if (rxrd_access && !rxrd_wait) begin
        take_output(1, "rxrd_packet", rxrd_packet);
      end
      if (rxrr_access && !rxrr_wait) begin
        if (tmo_phase && rxrr_packet == TMO_PACKET) begin
          tmo_seen++;
        end
        take_output(2, "rxrr_packet", rxrr_packet);
      end

      link_go = erx_access && !erx_wait;
      dma_go  = edma_access && !edma_wait;
      rr_hit  = link_go && is_response(erx_packet);
      issue   = 1'b0;

      // Responses go straight in, a timeout takes the slot
      if (m_tmo) begin
        exp_rr.push_back(TMO_PACKET);
      end else if (rr_hit) begin
        exp_rr.push_back(erx_packet);
      end

      // Remap register moves on only while erx_wait is low
      if (!erx_wait) begin
        if (pend_valid) begin
          if (pend_pkt[0]) begin
            if (pend_pkt[39:28] != LINK_ID) begin
              exp_wr.push_back(pend_pkt);
            end
          end else begin
            exp_rd.push_back(pend_pkt);
            issue = 1'b1;
          end
        end
        pend_valid = link_go;
        if (link_go) begin
          pend_pkt = apply_window(erx_packet);
        end
      end
      if (dma_go) begin
        exp_rd.push_back(edma_packet);
      end

      // Read timer, one outstanding read at a time
      tmo_next = 1'b0;
      if (m_busy) begin
        if (rr_hit) begin
          m_busy = 1'b0;
        end else begin
          m_cnt = m_cnt - 1;
          if (m_cnt == 0) begin
            tmo_next = 1'b1;
            m_busy   = 1'b0;
          end
        end
      end else if (issue && !rr_hit) begin
        m_busy = 1'b1;
        m_cnt  = TMO_CYCLES;
      end
      m_tmo = tmo_next;

      link_acc = link_go;
      dma_acc  = dma_go;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      errors++;
      $display("Run stopped after %0d cycles before the tests finished", cycles);
      $display("Checked %0d packets, %0d errors", checked, errors);
      $display("Test failed");
      $finish;
    end
  end

  //##########################################################################
  // Test sequence
  //##########################################################################

  initial begin
    rst         = 1'b1;
    erx_access  = 1'b0;
    erx_packet  = '0;
    edma_access = 1'b0;
    edma_packet = '0;
    rxwr_wait   = 1'b0;
    rxrd_wait   = 1'b0;
    rxrr_wait   = 1'b0;

    // Four cycles of reset, outputs checked after each
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_reset_state();
    end
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();

    // Random traffic under back-pressure
    repeat (STIM_CYCLES) begin
      @(negedge clk);
      drive_inputs(1'b1, 1'b1);
    end

    // Drain everything, timer included
    do begin
      @(negedge clk);
      drive_inputs(1'b0, 1'b0);
    end while (link_busy || dma_busy || pend_valid || m_busy || m_tmo ||
               exp_wr.size() != 0 || exp_rd.size() != 0 || exp_rr.size() != 0);

    // One unanswered read outside the window
    tmo_phase     = 1'b1;
    link_pkt      = {rand32(), rand32(), rand32(), 8'(rand32())};
    link_pkt[0]   = 1'b0;
    link_pkt[39:28] = 12'h123;
    link_busy     = 1'b1;
    repeat (TMO_CYCLES + 20) begin
      @(negedge clk);
      drive_inputs(1'b0, 1'b0);
    end
    tmo_phase = 1'b0;
    if (tmo_seen != 1) begin
      errors++;
      $display("Error: rxrr_packet timeout count expected %h got %h", 1, tmo_seen);
    end

    repeat (4) @(negedge clk);
    if (exp_wr.size() != 0 || exp_rd.size() != 0 || exp_rr.size() != 0) begin
      errors++;
      $display("Some expected packets never left the DUT");
    end
    $display("Checked %0d packets, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
erx_pkg.sv
erx_remap.sv
erx_read_timer.sv
erx_disty.sv
erx_fifo.sv
erx_top.sv
tb_erx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_erx
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass only if the exact pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
